// File: common/rx_pkg.sv
package rx_pkg;

    // sample and phase widths
    localparam int SAMPLE_DW = 16;
    localparam int PHASE_DW  = 16;

    // sine table, one full period
    localparam int TABLE_LEN   = 16;
    localparam int TABLE_AW    = $clog2(TABLE_LEN);
    localparam int TABLE_SHIFT = 14; // table amplitude is 2^14

    // cosine is sine advanced by a quarter period
    localparam logic [TABLE_AW-1:0] TABLE_QUARTER = TABLE_AW'(TABLE_LEN / 4);

    localparam logic signed [SAMPLE_DW-1:0] SIN_TABLE [TABLE_LEN] = '{
        16'sd0,
        16'sd6270,
        16'sd11585,
        16'sd15137,
        16'sd16384,
        16'sd15137,
        16'sd11585,
        16'sd6270,
        16'sd0,
        -16'sd6270,
        -16'sd11585,
        -16'sd15137,
        -16'sd16384,
        -16'sd15137,
        -16'sd11585,
        -16'sd6270
    };

    // cic, rate 2
    localparam int CIC_ORDER = 3;
    localparam int CIC_SHIFT = 3;                    // gain 2^3
    localparam int CIC_DW    = SAMPLE_DW + CIC_ORDER; // one bit growth per stage

    // sync sequence, bit 0 is the oldest sample
    localparam int                  SYNC_LEN    = 16;
    localparam int                  SYNC_CNT_DW = $clog2(SYNC_LEN + 1);
    localparam logic [SYNC_LEN-1:0] SYNC_SEQ    = 16'h35e4;
    localparam int                  CORR_DW     = 21;

    // frame layout
    localparam int SYMBOL_LEN        = 16;
    localparam int SAMP_CNT_DW       = $clog2(SYMBOL_LEN);
    localparam int SYMBOLS_PER_FRAME = 4;
    localparam int SYM_IDX_DW        = 2;

    // soft bits
    localparam int LLR_DW    = 8;
    localparam int LLR_SHIFT = 6;
    localparam logic signed [LLR_DW-1:0] LLR_MAX = {1'b0, {(LLR_DW - 1){1'b1}}};
    localparam logic signed [LLR_DW-1:0] LLR_MIN = {1'b1, {(LLR_DW - 1){1'b0}}};

endpackage

// File: common/iq_stream_if.sv
interface iq_stream_if;

    logic signed [rx_pkg::SAMPLE_DW-1:0]  re;
    logic signed [rx_pkg::SAMPLE_DW-1:0]  im;
    logic                                 valid;   // one sample per high cycle, no ready
    logic        [rx_pkg::SYM_IDX_DW-1:0] sym_idx;
    logic                                 last;    // end of symbol

    modport src (
        output re, im, valid, sym_idx, last
    );

    modport snk (
        input re, im, valid, sym_idx, last
    );

endinterface

// File: hw/cfo_rotator.sv
module cfo_rotator (
    input  logic                                clk_i,
    input  logic                                reset_ni,
    input  logic signed [rx_pkg::SAMPLE_DW-1:0] in_re_i,
    input  logic signed [rx_pkg::SAMPLE_DW-1:0] in_im_i,
    input  logic                                in_valid_i,
    input  logic        [rx_pkg::PHASE_DW-1:0]  cfo_inc_i,
    iq_stream_if.src                            out
);

    logic [rx_pkg::PHASE_DW-1:0] phase_q;
    logic [rx_pkg::TABLE_AW-1:0] sin_idx;
    logic [rx_pkg::TABLE_AW-1:0] cos_idx;

    // stage one
    logic signed [rx_pkg::SAMPLE_DW-1:0] s1_re_q;
    logic signed [rx_pkg::SAMPLE_DW-1:0] s1_im_q;
    logic signed [rx_pkg::SAMPLE_DW-1:0] s1_sin_q;
    logic signed [rx_pkg::SAMPLE_DW-1:0] s1_cos_q;
    logic                                s1_valid_q;

    // full precision products
    logic signed [2*rx_pkg::SAMPLE_DW:0] mul_re;
    logic signed [2*rx_pkg::SAMPLE_DW:0] mul_im;
    logic signed [2*rx_pkg::SAMPLE_DW:0] mul_re_sh;
    logic signed [2*rx_pkg::SAMPLE_DW:0] mul_im_sh;

    assign sin_idx = phase_q[rx_pkg::PHASE_DW-1 -: rx_pkg::TABLE_AW];
    assign cos_idx = sin_idx + rx_pkg::TABLE_QUARTER; // wraps mod table length

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            phase_q    <= '0;
            s1_valid_q <= 1'b0;
        end else begin
            s1_valid_q <= in_valid_i;
            if (in_valid_i) begin
                phase_q <= phase_q + cfo_inc_i; // sample uses the old phase
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (in_valid_i) begin
            s1_re_q  <= in_re_i;
            s1_im_q  <= in_im_i;
            s1_sin_q <= rx_pkg::SIN_TABLE[sin_idx];
            s1_cos_q <= rx_pkg::SIN_TABLE[cos_idx];
        end
    end

    // (re + j im) * (cos + j sin)
    assign mul_re    = s1_re_q * s1_cos_q - s1_im_q * s1_sin_q;
    assign mul_im    = s1_re_q * s1_sin_q + s1_im_q * s1_cos_q;
    assign mul_re_sh = mul_re >>> rx_pkg::TABLE_SHIFT;
    assign mul_im_sh = mul_im >>> rx_pkg::TABLE_SHIFT;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            out.valid <= 1'b0;
        end else begin
            out.valid <= s1_valid_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (s1_valid_q) begin
            out.re <= mul_re_sh[rx_pkg::SAMPLE_DW-1:0];
            out.im <= mul_im_sh[rx_pkg::SAMPLE_DW-1:0];
        end
    end

    assign out.sym_idx = '0;
    assign out.last    = 1'b0;

endmodule

// File: hw/cic_decimator.sv
module cic_decimator (
    input  logic     clk_i,
    input  logic     reset_ni,
    iq_stream_if.snk in,
    iq_stream_if.src out
);

    // index 0 is re, index 1 is im
    logic signed [rx_pkg::CIC_DW-1:0] x        [2];
    logic signed [rx_pkg::CIC_DW-1:0] integ_q  [2][rx_pkg::CIC_ORDER];
    logic signed [rx_pkg::CIC_DW-1:0] comb_dly_q [2][rx_pkg::CIC_ORDER];
    logic signed [rx_pkg::CIC_DW-1:0] comb     [2][rx_pkg::CIC_ORDER];
    logic signed [rx_pkg::CIC_DW-1:0] comb_sh  [2];
    logic                             dec_phase_q;
    logic                             dec_take;

    assign x[0] = in.re; // sign extended
    assign x[1] = in.im;

    assign dec_take = in.valid && dec_phase_q; // every second sample

    always_comb begin
        for (int c = 0; c < 2; c++) begin
            comb[c][0] = integ_q[c][rx_pkg::CIC_ORDER-1] - comb_dly_q[c][0];
            for (int k = 1; k < rx_pkg::CIC_ORDER; k++) begin
                comb[c][k] = comb[c][k-1] - comb_dly_q[c][k];
            end
            comb_sh[c] = comb[c][rx_pkg::CIC_ORDER-1] >>> rx_pkg::CIC_SHIFT;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            dec_phase_q <= 1'b0;
            integ_q     <= '{default: '{default: '0}};
            comb_dly_q  <= '{default: '{default: '0}};
            out.valid   <= 1'b0;
        end else begin
            out.valid <= dec_take;
            if (in.valid) begin
                dec_phase_q <= ~dec_phase_q;
                for (int c = 0; c < 2; c++) begin
                    integ_q[c][0] <= integ_q[c][0] + x[c];
                    for (int k = 1; k < rx_pkg::CIC_ORDER; k++) begin
                        integ_q[c][k] <= integ_q[c][k] + integ_q[c][k-1];
                    end
                end
            end
            if (dec_take) begin
                for (int c = 0; c < 2; c++) begin
                    comb_dly_q[c][0] <= integ_q[c][rx_pkg::CIC_ORDER-1];
                    for (int k = 1; k < rx_pkg::CIC_ORDER; k++) begin
                        comb_dly_q[c][k] <= comb[c][k-1];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (dec_take) begin
            out.re <= comb_sh[0][rx_pkg::SAMPLE_DW-1:0];
            out.im <= comb_sh[1][rx_pkg::SAMPLE_DW-1:0];
        end
    end

    assign out.sym_idx = '0;
    assign out.last    = 1'b0;

endmodule

// File: sync/sync_correlator.sv
module sync_correlator (
    input  logic                              clk_i,
    input  logic                              reset_ni,
    iq_stream_if.snk                          in,
    input  logic signed [rx_pkg::CORR_DW-1:0] threshold_i,
    output logic signed [rx_pkg::CORR_DW-1:0] corr_o,
    output logic                              corr_valid_o,
    output logic                              peak_o
);

    // window, index 0 is the oldest sample
    logic signed [rx_pkg::SAMPLE_DW-1:0] win_q   [rx_pkg::SYNC_LEN];
    logic signed [rx_pkg::SAMPLE_DW-1:0] win_nxt [rx_pkg::SYNC_LEN];
    logic signed [rx_pkg::CORR_DW-1:0]   corr_sum;
    logic        [rx_pkg::SYNC_CNT_DW-1:0] fill_q;
    logic                                window_full;

    // window including the incoming sample
    always_comb begin
        for (int k = 0; k < rx_pkg::SYNC_LEN - 1; k++) begin
            win_nxt[k] = win_q[k+1];
        end
        win_nxt[rx_pkg::SYNC_LEN-1] = in.re;
    end

    // sign correlation against the known sequence
    always_comb begin
        corr_sum = '0;
        for (int k = 0; k < rx_pkg::SYNC_LEN; k++) begin
            if (rx_pkg::SYNC_SEQ[k]) begin
                corr_sum = corr_sum + win_nxt[k];
            end else begin
                corr_sum = corr_sum - win_nxt[k];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            win_q        <= '{default: '0};
            fill_q       <= '0;
            corr_valid_o <= 1'b0;
        end else begin
            corr_valid_o <= in.valid;
            if (in.valid) begin
                win_q <= win_nxt;
                if (fill_q != rx_pkg::SYNC_CNT_DW'(rx_pkg::SYNC_LEN)) begin
                    fill_q <= fill_q + 1'b1; // saturates once full
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (in.valid) begin
            corr_o <= corr_sum;
        end
    end

    // fill_q reaches SYNC_LEN together with the value for the 16th sample
    assign window_full = (fill_q == rx_pkg::SYNC_CNT_DW'(rx_pkg::SYNC_LEN));

    assign peak_o = corr_valid_o && window_full && (corr_o >= threshold_i);

endmodule

// File: sync/frame_aligner.sv
module frame_aligner (
    input  logic     clk_i,
    input  logic     reset_ni,
    iq_stream_if.snk in,
    input  logic     peak_i,
    iq_stream_if.src out
);

    typedef enum logic {
        ST_IDLE,
        ST_BUSY
    } state_t;

    state_t                           state_q;
    logic [rx_pkg::SAMP_CNT_DW-1:0]   samp_cnt_q; // sample within symbol
    logic [rx_pkg::SYM_IDX_DW-1:0]    sym_cnt_q;  // symbol within frame
    logic                             take;
    logic                             sym_end;
    logic                             frame_end;

    assign take      = (state_q == ST_BUSY) && in.valid;
    assign sym_end   = (samp_cnt_q == rx_pkg::SAMP_CNT_DW'(rx_pkg::SYMBOL_LEN - 1));
    assign frame_end = sym_end
                       && (sym_cnt_q == rx_pkg::SYM_IDX_DW'(rx_pkg::SYMBOLS_PER_FRAME - 1));

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q    <= ST_IDLE;
            samp_cnt_q <= '0;
            sym_cnt_q  <= '0;
            out.valid  <= 1'b0;
            out.last   <= 1'b0;
        end else begin
            out.valid <= take;
            out.last  <= take && sym_end;
            case (state_q)
                ST_IDLE: begin
                    if (peak_i) begin
                        state_q <= ST_BUSY;
                    end
                end
                ST_BUSY: begin // peaks ignored here
                    if (in.valid) begin
                        samp_cnt_q <= samp_cnt_q + 1'b1;
                        if (sym_end) begin
                            samp_cnt_q <= '0;
                            sym_cnt_q  <= sym_cnt_q + 1'b1;
                        end
                        if (frame_end) begin
                            sym_cnt_q <= '0;
                            state_q   <= ST_IDLE;
                        end
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (take) begin
            out.re      <= in.re;
            out.im      <= in.im;
            out.sym_idx <= sym_cnt_q;
        end
    end

endmodule

// File: hw/llr_demap.sv
module llr_demap (
    input  logic                                 clk_i,
    input  logic                                 reset_ni,
    iq_stream_if.snk                             in,
    output logic signed [rx_pkg::LLR_DW-1:0]     llr_o,
    output logic        [rx_pkg::SYM_IDX_DW-1:0] llr_sym_idx_o,
    output logic                                 llr_last_o,
    output logic                                 llr_valid_o
);

    logic signed [rx_pkg::SAMPLE_DW-1:0] re_sh;
    logic signed [rx_pkg::LLR_DW-1:0]    llr_sat;

    assign re_sh = in.re >>> rx_pkg::LLR_SHIFT;

    // clip to the llr range
    always_comb begin
        if (re_sh > rx_pkg::LLR_MAX) begin
            llr_sat = rx_pkg::LLR_MAX;
        end else if (re_sh < rx_pkg::LLR_MIN) begin
            llr_sat = rx_pkg::LLR_MIN;
        end else begin
            llr_sat = re_sh[rx_pkg::LLR_DW-1:0];
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            llr_valid_o <= 1'b0;
            llr_last_o  <= 1'b0;
        end else begin
            llr_valid_o <= in.valid;
            llr_last_o  <= in.valid && in.last;
        end
    end

    always_ff @(posedge clk_i) begin
        if (in.valid) begin
            llr_o         <= llr_sat;
            llr_sym_idx_o <= in.sym_idx;
        end
    end

endmodule

// File: hw/rx_top.sv
module rx_top (
    input  logic                                 clk_i,
    input  logic                                 reset_ni,
    input  logic signed [rx_pkg::SAMPLE_DW-1:0]  in_re_i,
    input  logic signed [rx_pkg::SAMPLE_DW-1:0]  in_im_i,
    input  logic                                 in_valid_i,
    input  logic        [rx_pkg::PHASE_DW-1:0]   cfo_inc_i,
    input  logic signed [rx_pkg::CORR_DW-1:0]    threshold_i,
    output logic signed [rx_pkg::LLR_DW-1:0]     llr_o,
    output logic        [rx_pkg::SYM_IDX_DW-1:0] llr_sym_idx_o,
    output logic                                 llr_last_o,
    output logic                                 llr_valid_o,
    output logic signed [rx_pkg::SAMPLE_DW-1:0]  dec_re_debug_o,
    output logic signed [rx_pkg::SAMPLE_DW-1:0]  dec_im_debug_o,
    output logic                                 dec_valid_debug_o,
    output logic signed [rx_pkg::CORR_DW-1:0]    corr_debug_o,
    output logic                                 corr_valid_debug_o,
    output logic                                 peak_debug_o
);

    iq_stream_if rot_s ();
    iq_stream_if dec_s ();
    iq_stream_if frm_s ();

    logic peak;

    cfo_rotator cfo_rotator_i (
        .clk_i      (clk_i),
        .reset_ni   (reset_ni),
        .in_re_i    (in_re_i),
        .in_im_i    (in_im_i),
        .in_valid_i (in_valid_i),
        .cfo_inc_i  (cfo_inc_i),
        .out        (rot_s.src)
    );

    cic_decimator cic_decimator_i (
        .clk_i    (clk_i),
        .reset_ni (reset_ni),
        .in       (rot_s.snk),
        .out      (dec_s.src)
    );

    sync_correlator sync_correlator_i (
        .clk_i        (clk_i),
        .reset_ni     (reset_ni),
        .in           (dec_s.snk),
        .threshold_i  (threshold_i),
        .corr_o       (corr_debug_o),
        .corr_valid_o (corr_valid_debug_o),
        .peak_o       (peak)
    );

    frame_aligner frame_aligner_i (
        .clk_i    (clk_i),
        .reset_ni (reset_ni),
        .in       (dec_s.snk),
        .peak_i   (peak),
        .out      (frm_s.src)
    );

    llr_demap llr_demap_i (
        .clk_i         (clk_i),
        .reset_ni      (reset_ni),
        .in            (frm_s.snk),
        .llr_o         (llr_o),
        .llr_sym_idx_o (llr_sym_idx_o),
        .llr_last_o    (llr_last_o),
        .llr_valid_o   (llr_valid_o)
    );

    // debug taps
    assign dec_re_debug_o    = dec_s.re;
    assign dec_im_debug_o    = dec_s.im;
    assign dec_valid_debug_o = dec_s.valid;
    assign peak_debug_o      = peak;

endmodule

// File: verif/rx_tb.sv
module rx_tb;

    localparam int THR_NEVER    = 1048575; // above any reachable sum
    localparam int THR_SYNC     = 40000;
    localparam int STIM_SAMPLES = 200 + 200 + 456 + 272;
    localparam int WATCHDOG_CYC = 2 * STIM_SAMPLES + 4 * 60 + 200; // gaps double the worst case

    logic                                 clk = 1'b0;
    logic                                 reset_n;
    logic signed [rx_pkg::SAMPLE_DW-1:0]  in_re;
    logic signed [rx_pkg::SAMPLE_DW-1:0]  in_im;
    logic                                 in_valid;
    logic        [rx_pkg::PHASE_DW-1:0]   cfo_inc;
    logic signed [rx_pkg::CORR_DW-1:0]    threshold;
    logic signed [rx_pkg::LLR_DW-1:0]     llr;
    logic        [rx_pkg::SYM_IDX_DW-1:0] llr_idx;
    logic                                 llr_last;
    logic                                 llr_valid;
    logic signed [rx_pkg::SAMPLE_DW-1:0]  dec_re;
    logic signed [rx_pkg::SAMPLE_DW-1:0]  dec_im;
    logic                                 dec_valid;
    logic signed [rx_pkg::CORR_DW-1:0]    corr;
    logic                                 corr_valid;
    logic                                 peak;

    logic [31:0] lfsr = 32'hc411_2f68;
    int          value_errs = 0;
    int          other_errs = 0;
    int          llr_seen   = 0; // llrs from the dut in the current test
    string       test_name  = "";

    // reference model state
    logic [rx_pkg::PHASE_DW-1:0] phase_m;
    int hre [7]; // index 0 is the newest rotated sample
    int him [7];
    int win [rx_pkg::SYNC_LEN];
    int n_in, fill, fr_cnt, frames, n_max, n_min;
    bit busy;

    // expected outputs
    int exp_dec_re [$];
    int exp_dec_im [$];
    int exp_corr   [$];
    bit exp_peak   [$];
    int exp_llr    [$];
    int exp_idx    [$];
    bit exp_last   [$];
    int e0, e1;
    bit eb;

    rx_top uut (
        .clk_i              (clk),
        .reset_ni           (reset_n),
        .in_re_i            (in_re),
        .in_im_i            (in_im),
        .in_valid_i         (in_valid),
        .cfo_inc_i          (cfo_inc),
        .threshold_i        (threshold),
        .llr_o              (llr),
        .llr_sym_idx_o      (llr_idx),
        .llr_last_o         (llr_last),
        .llr_valid_o        (llr_valid),
        .dec_re_debug_o     (dec_re),
        .dec_im_debug_o     (dec_im),
        .dec_valid_debug_o  (dec_valid),
        .corr_debug_o       (corr),
        .corr_valid_debug_o (corr_valid),
        .peak_debug_o       (peak)
    );

    always #5 clk = ~clk;

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v = (v << 1) | int'(lfsr[0]);
        end
        return v;
    endfunction

    function automatic int wrap16(input longint v);
        logic signed [15:0] t;
        t = v[15:0];
        return int'(t);
    endfunction

    function automatic int soft_bit(input int re);
        int v;
        v = re >>> rx_pkg::LLR_SHIFT;
        if (v > 127) v = 127;
        if (v < -128) v = -128;
        return v;
    endfunction

    task automatic value_fail(input string name, input int expv, input int actv);
        value_errs++;
        $display("Fail %s %s: expected %0d, actual %0d", test_name, name, expv, actv);
    endtask

    task automatic other_fail(input string what);
        other_errs++;
        $display("Error at %0t: %s", $time, what);
    endtask

    task automatic model_clear();
        phase_m = '0;
        hre = '{default: 0};
        him = '{default: 0};
        win = '{default: 0};
        n_in = 0;
        fill = 0;
        fr_cnt = 0;
        frames = 0;
        n_max = 0;
        n_min = 0;
        busy = 1'b0;
    endtask

    // frame gating, correlation and peak for one decimated sample
    task automatic model_dec(input int dr);
        int c;
        if (busy) begin
            exp_llr.push_back(soft_bit(dr));
            exp_idx.push_back(fr_cnt / rx_pkg::SYMBOL_LEN);
            exp_last.push_back(fr_cnt % rx_pkg::SYMBOL_LEN == rx_pkg::SYMBOL_LEN - 1);
            if (soft_bit(dr) == 127) n_max++;
            if (soft_bit(dr) == -128) n_min++;
            fr_cnt++;
            if (fr_cnt == rx_pkg::SYMBOL_LEN * rx_pkg::SYMBOLS_PER_FRAME) busy = 1'b0;
        end
        for (int k = 0; k < rx_pkg::SYNC_LEN - 1; k++) win[k] = win[k+1];
        win[rx_pkg::SYNC_LEN-1] = dr;
        if (fill < rx_pkg::SYNC_LEN) fill++;
        c = 0;
        for (int k = 0; k < rx_pkg::SYNC_LEN; k++) begin
            c = rx_pkg::SYNC_SEQ[k] ? c + win[k] : c - win[k];
        end
        exp_corr.push_back(c);
        exp_peak.push_back(fill == rx_pkg::SYNC_LEN && c >= int'(threshold));
        if (fill == rx_pkg::SYNC_LEN && c >= int'(threshold) && !busy) begin
            busy = 1'b1;
            fr_cnt = 0;
            frames++;
        end
    endtask

    // rotation, then a rate 2 cic seen as taps 1 3 3 1 three samples late
    task automatic model_in(input int re, input int im);
        int si, ci, dr, di;
        longint pr, pi;
        si = int'(phase_m[rx_pkg::PHASE_DW-1 -: 4]);
        ci = (si + rx_pkg::TABLE_LEN / 4) % rx_pkg::TABLE_LEN;
        pr = longint'(re) * rx_pkg::SIN_TABLE[ci] - longint'(im) * rx_pkg::SIN_TABLE[si];
        pi = longint'(re) * rx_pkg::SIN_TABLE[si] + longint'(im) * rx_pkg::SIN_TABLE[ci];
        phase_m = phase_m + cfo_inc;
        for (int k = 6; k > 0; k--) begin
            hre[k] = hre[k-1];
            him[k] = him[k-1];
        end
        hre[0] = wrap16(pr >>> rx_pkg::TABLE_SHIFT);
        him[0] = wrap16(pi >>> rx_pkg::TABLE_SHIFT);
        n_in++;
        if (n_in % 2 == 0) begin
            dr = wrap16((hre[3] + 3 * hre[4] + 3 * hre[5] + hre[6]) >>> rx_pkg::CIC_SHIFT);
            di = wrap16((him[3] + 3 * him[4] + 3 * him[5] + him[6]) >>> rx_pkg::CIC_SHIFT);
            exp_dec_re.push_back(dr);
            exp_dec_im.push_back(di);
            model_dec(dr);
        end
    endtask

    task automatic send(input int re, input int im);
        if (rand_bits(2) == 0) begin // idle cycle now and then
            in_valid = 1'b0;
            @(posedge clk);
            #1;
        end
        in_re    = 16'(re);
        in_im    = 16'(im);
        in_valid = 1'b1;
        model_in(re, im);
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic send_noise(input int n);
        for (int i = 0; i < n; i++) send(rand_bits(12) - 2048, rand_bits(12) - 2048);
    endtask

    task automatic send_large(input int n);
        for (int i = 0; i < n; i++) begin
            send(rand_bits(1) ? 16000 + rand_bits(13) : -16000 - rand_bits(13), 0);
        end
    endtask

    // each chip held for two inputs, one decimated sample
    task automatic send_sync();
        for (int k = 0; k < rx_pkg::SYNC_LEN; k++) begin
            send(rx_pkg::SYNC_SEQ[k] ? 4096 : -4096, 0);
            send(rx_pkg::SYNC_SEQ[k] ? 4096 : -4096, 0);
        end
    endtask

    task automatic apply_reset(input string name, input logic [15:0] inc, input int thr);
        test_name = name;
        llr_seen  = 0;
        reset_n   = 1'b0;
        in_valid  = 1'b0;
        cfo_inc   = inc;
        threshold = 21'(thr);
        model_clear();
        repeat (3) @(posedge clk);
        #1;
        reset_n = 1'b1;
    endtask

    task automatic drain();
        for (int i = 0; i < 50 && (exp_dec_re.size() + exp_corr.size() + exp_llr.size()) > 0;
             i++) begin
            @(posedge clk);
        end
        assert (exp_dec_re.size() + exp_corr.size() + exp_llr.size() == 0)
            else other_fail("expected outputs never appeared");
        @(posedge clk);
        #1;
    endtask

    // compare outputs on the falling edge
    always @(negedge clk) begin
        if (!reset_n) begin
            assert (!dec_valid && !corr_valid && !peak && !llr_valid && !llr_last)
                else other_fail("output active during reset");
        end else begin
            if (dec_valid) begin
                if (exp_dec_re.size() == 0) begin
                    other_fail("unexpected decimated sample");
                end else begin
                    e0 = exp_dec_re.pop_front();
                    e1 = exp_dec_im.pop_front();
                    assert (dec_re == e0) else value_fail("dec_re", e0, int'(dec_re));
                    assert (dec_im == e1) else value_fail("dec_im", e1, int'(dec_im));
                end
            end
            if (corr_valid) begin
                if (exp_corr.size() == 0) begin
                    other_fail("unexpected correlation value");
                end else begin
                    e0 = exp_corr.pop_front();
                    eb = exp_peak.pop_front();
                    assert (corr == e0) else value_fail("corr", e0, int'(corr));
                    assert (peak == eb) else value_fail("peak", int'(eb), int'(peak));
                end
            end else begin
                assert (!peak) else other_fail("peak without correlation value");
            end
            if (llr_valid) begin
                llr_seen++;
                if (exp_llr.size() == 0) begin
                    other_fail("unexpected llr");
                end else begin
                    e0 = exp_llr.pop_front();
                    e1 = exp_idx.pop_front();
                    eb = exp_last.pop_front();
                    assert (llr == e0) else value_fail("llr", e0, int'(llr));
                    assert (llr_idx == e1) else value_fail("llr_sym_idx", e1, int'(llr_idx));
                    assert (llr_last == eb) else value_fail("llr_last", int'(eb), int'(llr_last));
                end
            end else begin
                assert (!llr_last) else other_fail("llr_last without llr_valid");
            end
        end
    end

    initial begin
        #(10 * WATCHDOG_CYC);
        $display("watchdog expired before the tests completed");
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        reset_n   = 1'b0;
        in_re     = '0;
        in_im     = '0;
        in_valid  = 1'b0;
        cfo_inc   = '0;
        threshold = '0;
        // plain cic path, no frames
        apply_reset("plain_cic", 16'h0000, THR_NEVER);
        send_noise(200);
        drain();
        assert (llr_seen == 0) else other_fail("llr output with unreachable threshold");
        // quarter turn per sample
        apply_reset("quarter_turn", 16'h4000, THR_NEVER);
        send_noise(200);
        drain();
        // one frame, a sync inside it, then a second frame
        apply_reset("frame_align", 16'h0000, THR_SYNC);
        send_noise(40);
        send_sync();
        send_noise(40);
        send_sync();
        send_noise(120);
        send_sync();
        send_noise(160);
        drain();
        assert (frames == 2) else value_fail("frame_count", 2, frames);
        assert (llr_seen == 2 * rx_pkg::SYMBOLS_PER_FRAME * rx_pkg::SYMBOL_LEN)
            else value_fail("frame_llrs", 2 * rx_pkg::SYMBOLS_PER_FRAME * rx_pkg::SYMBOL_LEN,
                            llr_seen);
        // saturating soft bits
        apply_reset("llr_saturation", 16'h0000, THR_SYNC);
        send_noise(40);
        send_sync();
        send_large(200);
        drain();
        assert (n_max > 0 && n_min > 0) else other_fail("llr saturation limits not reached");
        $display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: rx_top.f
common/rx_pkg.sv
common/iq_stream_if.sv
hw/cfo_rotator.sv
hw/cic_decimator.sv
sync/sync_correlator.sv
sync/frame_aligner.sv
hw/llr_demap.sv
hw/rx_top.sv
verif/rx_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the rx_top testbench with Verilator and runs it
cd "$(dirname "$0")" &&
rm -rf obj_dir sim.log &&
verilator --binary --timing -Wno-fatal --top-module rx_tb -f rx_top.f -o rx_sim &&
./obj_dir/rx_sim | tee sim.log &&
grep -q "^Simulation finished: PASS$" sim.log &&
echo "run_sim: passed" && exit 0 ||
{ echo "run_sim: failed"; exit 1; }
